//--- include/arith_ref.svh
/*
  Expected outputs of the core, packed as {result, overflow, zero, nan,
  precision_lost}. The including module must import fixfloat_pkg.
  Float rules flush subnormals to zero and truncate the fraction.
*/
`ifndef ARITH_REF_SVH
`define ARITH_REF_SVH

function automatic logic [19:0] add_fixed(input logic [15:0] x, input logic [15:0] y);
  logic [16:0] s;
  s = {1'b0, x} + {1'b0, y};
  return {s[15:0], s[16], 3'b000};   // carry is the overflow
endfunction

function automatic logic [19:0] mul_fixed(input logic [15:0] x, input logic [15:0] y);
  logic [31:0] p;
  p = {16'h0, x} * {16'h0, y};       // 16.16
  return {p[FIX_FRAC_W +: WORD_W], |p[31:24], 2'b00, |p[FIX_FRAC_W-1:0]};
endfunction

function automatic logic [19:0] mul_float(input logic [15:0] x, input logic [15:0] y);
  fp16_t       fx;
  fp16_t       fy;
  logic        sign;
  int          ex;
  int          ey;
  int          mx;
  int          my;
  int          p;
  int          e;
  logic        norm;
  logic        lost;
  logic [9:0]  frac;
  fx   = x;
  fy   = y;
  sign = fx.sign ^ fy.sign;
  ex   = int'(fx.exponent);
  ey   = int'(fy.exponent);
  mx   = int'(fx.fraction);
  my   = int'(fy.fraction);
  if ((ex == EXP_MAX && mx != 0) || (ey == EXP_MAX && my != 0) ||
      (ex == EXP_MAX && ey == 0) || (ey == EXP_MAX && ex == 0))
    return {QNAN, 4'b0010};
  if (ex == EXP_MAX || ey == EXP_MAX)
    return {sign, 5'h1f, 10'h000, 4'b1000};
  if (ex == 0 || ey == 0)
    return {sign, 15'h0000, 4'b0100};   // subnormals count as zero
  p    = (mx + 1024) * (my + 1024);      // 1.x times 1.x, 22 bits
  norm = (p >= (1 << 21));
  if (norm)
  begin
    frac = 10'((p >> 11) % 1024);
    lost = (p % 2048) != 0;
    e    = ex + ey - EXP_BIAS + 1;
  end
  else
  begin
    frac = 10'((p >> 10) % 1024);
    lost = (p % 1024) != 0;
    e    = ex + ey - EXP_BIAS;
  end
  if (e >= EXP_MAX)
    return {sign, 5'h1f, 10'h000, 3'b100, lost};
  if (e <= 0)
    return {sign, 15'h0000, 4'b0101};
  return {sign, 5'(e), frac, 3'b000, lost};
endfunction

function automatic logic [19:0] predict(input op_t code, input logic [15:0] x,
                                        input logic [15:0] y);
  case (code)
    OP_FIX_MUL: return mul_fixed(x, y);
    OP_FLT_MUL: return mul_float(x, y);
    default:    return add_fixed(x, y);   // code 3 too
  endcase
endfunction

`endif

//--- dv/tb_arith_core.sv
/*
  Self-checking testbench for arith_core against the functions in arith_ref.svh.
  Inputs change on the falling edge and outputs are sampled on the rising edge.
  Every operation's expected outputs wait in a queue until out_valid pops them.
  out_valid is also checked every cycle against in_valid from two edges back.
*/
`timescale 1ns/1ps

module tb_arith_core
  import fixfloat_pkg::*;
();

  `include "arith_ref.svh"

  // 304 adds, 364 fixed muls, 500 float muls, 100 mixed, plus idle gaps
  localparam int NUM_OPS    = 1268;
  localparam int MAX_CYCLES = 3000;   // about twice the ~1450 cycles needed

  logic              clk;
  logic              reset;
  logic              in_valid;
  op_t               op;
  logic [WORD_W-1:0] a;
  logic [WORD_W-1:0] b;
  logic              out_valid;
  logic [WORD_W-1:0] result;
  logic              overflow;
  logic              zero;
  logic              nan;
  logic              precision_lost;

  logic [19:0] expect_q [$];   // {result, overflow, zero, nan, precision_lost}
  logic [19:0] expected;
  logic [1:0]  valid_pipe;
  int          error_count;
  int          cycle_count;
  logic [15:0] specials [10];
  logic [15:0] r;

  arith_core u_dut
  (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .op             (op),
    .a              (a),
    .b              (b),
    .out_valid      (out_valid),
    .result         (result),
    .overflow       (overflow),
    .zero           (zero),
    .nan            (nan),
    .precision_lost (precision_lost)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] random_word();
    logic [31:0] w;
    w = $urandom();
    return w[15:0];
  endfunction

  // normal binary16 with a random sign, exponent 1..30 and fraction
  function automatic logic [15:0] random_normal();
    logic [15:0] w;
    logic [4:0]  e;
    w = random_word();
    e = 5'(1 + (w[14:10] % 30));
    return {w[15], e, w[9:0]};
  endfunction

  task automatic compare_value(input string name, input logic [15:0] want,
                               input logic [15:0] got);
    assert (got === want)
    else
    begin
      error_count++;
      $display("CHECK FAILED %s expected %h got %h", name, want, got);
    end
  endtask

  task automatic send_op(input op_t code, input logic [15:0] x, input logic [15:0] y);
    @(negedge clk);
    in_valid = 1'b1;
    op       = code;
    a        = x;
    b        = y;
    expect_q.push_back(predict(code, x, y));
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // reads the values registered on the previous edge
  always @(posedge clk)
  begin
    if (!reset)
    begin
      compare_value("out_valid", 16'(valid_pipe[1]), 16'(out_valid));
      if (out_valid)
      begin
        assert (expect_q.size() != 0)
        else
        begin
          error_count++;
          $display("out_valid was high with no operation outstanding");
        end
        if (expect_q.size() != 0)
        begin
          expected = expect_q.pop_front();
          compare_value("result", expected[19:4], result);
          compare_value("overflow", 16'(expected[3]), 16'(overflow));
          compare_value("zero", 16'(expected[2]), 16'(zero));
          compare_value("nan", 16'(expected[1]), 16'(nan));
          compare_value("precision_lost", 16'(expected[0]), 16'(precision_lost));
        end
      end
    end
    valid_pipe = {valid_pipe[0], in_valid};
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("errors: %0d, operations outstanding: %0d", error_count, expect_q.size());
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    reset       = 1'b1;
    in_valid    = 1'b0;
    op          = OP_FIX_ADD;
    a           = '0;
    b           = '0;
    valid_pipe  = 2'b00;
    error_count = 0;
    cycle_count = 0;
    void'($urandom(5790));
    specials = '{16'h7e00, 16'h7c01, 16'h7c00, 16'hfc00, 16'h0000,
                 16'h8000, 16'h0001, 16'h3c00, 16'hc000, 16'h7bff};

    repeat (3) @(posedge clk);   // three reset edges
    @(negedge clk);
    reset = 1'b0;
    // all outputs idle before the first strobe
    compare_value("out_valid", 16'h0, 16'(out_valid));
    compare_value("overflow", 16'h0, 16'(overflow));
    compare_value("zero", 16'h0, 16'(zero));
    compare_value("nan", 16'h0, 16'(nan));
    compare_value("precision_lost", 16'h0, 16'(precision_lost));
    go_idle(2);

    // fixed add with the carry corners first
    send_op(OP_FIX_ADD, 16'hffff, 16'h0001);
    send_op(OP_FIX_ADD, 16'h8000, 16'h8000);
    send_op(OP_FIX_ADD, 16'hffff, 16'hffff);
    send_op(OP_FIX_ADD, 16'h0000, 16'h0000);
    for (int i = 0; i < 300; i++)
    begin
      send_op(OP_FIX_ADD, random_word(), random_word());
      if (i % 8 == 7)
        go_idle(1);
    end
    go_idle(1);

    // fixed mul on whole numbers 0..7 then random pairs
    for (int i = 0; i < 8; i++)
    begin
      for (int j = 0; j < 8; j++)
        send_op(OP_FIX_MUL, 16'(i << FIX_FRAC_W), 16'(j << FIX_FRAC_W));
    end
    for (int i = 0; i < 300; i++)
    begin
      send_op(OP_FIX_MUL, random_word(), random_word());
      if (i % 8 == 7)
        go_idle(1);
    end
    go_idle(1);

    for (int i = 0; i < 400; i++)
    begin
      send_op(OP_FLT_MUL, random_normal(), random_normal());
      if (i % 8 == 7)
        go_idle(1);
    end
    go_idle(1);

    // every pairing of the special operands
    for (int i = 0; i < 10; i++)
    begin
      for (int j = 0; j < 10; j++)
        send_op(OP_FLT_MUL, specials[i], specials[j]);
    end
    go_idle(1);

    // mixed burst with in_valid held high and code 3 included
    for (int i = 0; i < 100; i++)
    begin
      r = random_word();
      send_op(op_t'(r[1:0]), random_word(), random_word());
    end
    go_idle(4);

    assert (expect_q.size() == 0)
    else
    begin
      error_count++;
      $display("%0d operations never produced an output", expect_q.size());
    end
    $display("errors: %0d, operations sent: %0d", error_count, NUM_OPS);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- hdl/arith_core.sv
/*
  Two stage arithmetic core, fixed latency of two cycles, no back-pressure.
  Operands and op are captured on in_valid, the selected unit output is
  registered on the next edge. result keeps its last value between outputs
  and is undefined until the first one. Op code 3 behaves as fixed addition.
*/
`timescale 1ns/1ps

module arith_core
  import fixfloat_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  op_t               op,
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  output logic              out_valid,
  output logic [WORD_W-1:0] result,
  output logic              overflow,
  output logic              zero,
  output logic              nan,
  output logic              precision_lost
);

  // stage 1
  logic              s1_valid;
  op_t               s1_op;
  logic [WORD_W-1:0] s1_a;
  logic [WORD_W-1:0] s1_b;

  // unit outputs
  logic [WORD_W-1:0] fix_sum;
  logic              fix_sum_ovf;
  logic [WORD_W-1:0] fix_prod;
  logic              fix_prod_ovf;
  logic              fix_prod_lost;
  fp16_t             flt_result;
  logic              flt_ovf;
  logic              flt_zero;
  logic              flt_nan;
  logic              flt_lost;

  // selected result ahead of stage 2
  logic [WORD_W-1:0] sel_result;
  logic              sel_ovf;
  logic              sel_zero;
  logic              sel_nan;
  logic              sel_lost;

  always_ff @(posedge clk)
  begin
    if (reset)
      s1_valid <= 1'b0;
    else
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      s1_op <= op;
      s1_a  <= a;
      s1_b  <= b;
    end
  end

  fixed_unit u_fixed
  (
    .a                (s1_a),
    .b                (s1_b),
    .sum              (fix_sum),
    .sum_overflow     (fix_sum_ovf),
    .product          (fix_prod),
    .product_overflow (fix_prod_ovf),
    .product_lost     (fix_prod_lost)
  );

  float_mul_unit u_float
  (
    .a              (s1_a),
    .b              (s1_b),
    .result         (flt_result),
    .overflow       (flt_ovf),
    .zero           (flt_zero),
    .nan            (flt_nan),
    .precision_lost (flt_lost)
  );

  always_comb
  begin
    sel_result = fix_sum;   // fixed add and the spare code
    sel_ovf    = fix_sum_ovf;
    sel_zero   = 1'b0;
    sel_nan    = 1'b0;
    sel_lost   = 1'b0;
    case (s1_op)
      OP_FIX_MUL:
      begin
        sel_result = fix_prod;
        sel_ovf    = fix_prod_ovf;
        sel_lost   = fix_prod_lost;
      end
      OP_FLT_MUL:
      begin
        sel_result = flt_result;
        sel_ovf    = flt_ovf;
        sel_zero   = flt_zero;
        sel_nan    = flt_nan;
        sel_lost   = flt_lost;
      end
      default:
      begin
      end
    endcase
  end

  // stage 2, flags cleared by reset, result only loads on a valid op
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid      <= 1'b0;
      overflow       <= 1'b0;
      zero           <= 1'b0;
      nan            <= 1'b0;
      precision_lost <= 1'b0;
    end
    else
    begin
      out_valid <= s1_valid;
      if (s1_valid)
      begin
        overflow       <= sel_ovf;
        zero           <= sel_zero;
        nan            <= sel_nan;
        precision_lost <= sel_lost;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (s1_valid)
      result <= sel_result;
  end

endmodule

//--- hdl/fixed_unit.sv
/*
  Unsigned 8.8 fixed point sum and product, purely combinational.
  Sum wraps at 16 bits with the carry on sum_overflow.
  Product is truncated, never rounded. Bits above the 8.8 range raise
  product_overflow and bits below it raise product_lost.
*/
`timescale 1ns/1ps

module fixed_unit
  import fixfloat_pkg::*;
(
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  output logic [WORD_W-1:0] sum,
  output logic              sum_overflow,
  output logic [WORD_W-1:0] product,
  output logic              product_overflow,
  output logic              product_lost
);

  logic [FIX_PROD_W-1:0] full_prod;   // 16.16 product

  // plain binary add, the binary point lines up on both operands
  assign {sum_overflow, sum} = {1'b0, a} + {1'b0, b};

  partial_product_array
  #(
    .A_W (WORD_W),
    .B_W (WORD_W)
  )
  u_ppa
  (
    .multiplicand (a),
    .multiplier   (b),
    .product      (full_prod)
  );

  // back to 8.8 by dropping the low fraction byte
  assign product = full_prod[FIX_FRAC_W +: WORD_W];

  // integer part beyond 8 bits
  assign product_overflow = |full_prod[FIX_PROD_W-1:WORD_W+FIX_FRAC_W];

  assign product_lost = |full_prod[FIX_FRAC_W-1:0];  // truncated fraction bits

endmodule

//--- hdl/fixfloat_pkg.sv
/*
  Shared widths, op codes and float field layout for the arithmetic core.
  Fixed point is unsigned 8.8. Floats are binary16 with subnormals flushed
  to zero, so only the normal, zero, infinity and NaN classes exist here.
  Op code 3 is not named and the core treats it as a fixed addition.
*/
package fixfloat_pkg;

  // operand and result width
  localparam int WORD_W = 16;

  // fixed point, IIIIIIII.FFFFFFFF
  localparam int FIX_FRAC_W = 8;
  localparam int FIX_PROD_W = 2 * WORD_W;   // full product before rescale

  // binary16 fields
  localparam int EXP_W    = 5;
  localparam int FRAC_W   = 10;
  localparam int MANT_W   = FRAC_W + 1;     // hidden one included
  localparam int EXP_BIAS = 15;
  localparam int EXP_MAX  = 31;             // infinity and NaN exponent

  // canonical quiet NaN, positive sign, msb of fraction set
  localparam logic [WORD_W-1:0] QNAN = 16'h7e00;

  // operation select
  typedef enum logic [1:0]
  {
    OP_FIX_ADD = 2'd0,
    OP_FIX_MUL = 2'd1,
    OP_FLT_MUL = 2'd2
  } op_t;

  /*
    SEEEEEFFFFFFFFFF = (-1)^S * 1.F * 2^(E - 15) for normal numbers
  */
  typedef struct packed
  {
    logic              sign;
    logic [EXP_W-1:0]  exponent;
    logic [FRAC_W-1:0] fraction;
  } fp16_t;

endpackage

//--- hdl/float_mul_unit.sv
/*
  binary16 multiplier, combinational, truncating toward zero.
  Subnormal operands count as zero and subnormal results flush to signed
  zero with precision_lost set. Every NaN out is the canonical QNAN.
  Flag priority is nan, then infinity operand, then zero operand, then the
  normal path with its own overflow and underflow checks.
*/
`timescale 1ns/1ps

module float_mul_unit
  import fixfloat_pkg::*;
(
  input  fp16_t a,
  input  fp16_t b,
  output fp16_t result,
  output logic  overflow,
  output logic  zero,
  output logic  nan,
  output logic  precision_lost
);

  logic                  a_nan;
  logic                  b_nan;
  logic                  a_inf;
  logic                  b_inf;
  logic                  a_zero;
  logic                  b_zero;
  logic                  sign_r;
  logic [MANT_W-1:0]     mant_a;
  logic [MANT_W-1:0]     mant_b;
  logic [2*MANT_W-1:0]   mant_prod;
  logic                  norm;
  logic [FRAC_W-1:0]     frac_r;
  logic                  dropped;
  int                    exp_calc;

  // operand classes
  assign a_nan  = (a.exponent == EXP_MAX) && (a.fraction != '0);
  assign b_nan  = (b.exponent == EXP_MAX) && (b.fraction != '0);
  assign a_inf  = (a.exponent == EXP_MAX) && (a.fraction == '0);
  assign b_inf  = (b.exponent == EXP_MAX) && (b.fraction == '0);
  assign a_zero = (a.exponent == '0);   // subnormals land here too
  assign b_zero = (b.exponent == '0);

  assign sign_r = a.sign ^ b.sign;

  // hidden one is always set, zero operands are handled before use
  assign mant_a = {1'b1, a.fraction};
  assign mant_b = {1'b1, b.fraction};

  partial_product_array
  #(
    .A_W (MANT_W),
    .B_W (MANT_W)
  )
  u_ppa
  (
    .multiplicand (mant_a),
    .multiplier   (mant_b),
    .product      (mant_prod)
  );

  // product of two 1.x mantissas lies in [1, 4)
  assign norm = mant_prod[2*MANT_W-1];

  assign frac_r = norm ? mant_prod[2*MANT_W-2 -: FRAC_W]
                       : mant_prod[2*MANT_W-3 -: FRAC_W];

  // everything below the kept fraction
  assign dropped = norm ? |mant_prod[FRAC_W:0] : |mant_prod[FRAC_W-1:0];

  // unbiased sum rebiased once, signed so underflow shows as <= 0
  assign exp_calc = int'(a.exponent) + int'(b.exponent) + int'(norm) - EXP_BIAS;

  always_comb
  begin
    result         = '0;
    overflow       = 1'b0;
    zero           = 1'b0;
    nan            = 1'b0;
    precision_lost = 1'b0;
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero))
    begin
      nan    = 1'b1;
      result = fp16_t'(QNAN);
    end
    else if (a_inf || b_inf)
    begin
      overflow        = 1'b1;
      result.sign     = sign_r;
      result.exponent = EXP_W'(EXP_MAX);
    end
    else if (a_zero || b_zero)
    begin
      zero        = 1'b1;
      result.sign = sign_r;   // signed zero
    end
    else
    begin
      result.sign    = sign_r;
      precision_lost = dropped;
      if (exp_calc >= EXP_MAX)
      begin
        overflow        = 1'b1;   // too large, saturate to infinity
        result.exponent = EXP_W'(EXP_MAX);
      end
      else if (exp_calc <= 0)
      begin
        // would be subnormal or smaller
        zero           = 1'b1;
        precision_lost = 1'b1;
      end
      else
      begin
        result.exponent = exp_calc[EXP_W-1:0];
        result.fraction = frac_r;
      end
    end
  end

endmodule

//--- hdl/partial_product_array.sv
/*
  Unsigned combinational multiplier, no pipelining.
  Each multiplier bit gates one shifted copy of the multiplicand. The copies
  are summed in four interleaved groups before the final add, so the depth
  of the adder chain grows with B_W / 4.
*/
`timescale 1ns/1ps

module partial_product_array
#(
  parameter int A_W = 16,
  parameter int B_W = 16
)
(
  input  logic [A_W-1:0]     multiplicand,
  input  logic [B_W-1:0]     multiplier,
  output logic [A_W+B_W-1:0] product
);

  logic [A_W+B_W-1:0] pp [B_W];        // gated shifted copies
  logic [A_W+B_W-1:0] group_sum [4];

  // one copy per multiplier bit
  always_comb
  begin
    for (int i = 0; i < B_W; i++)
    begin
      pp[i] = ({{B_W{1'b0}}, multiplicand} << i) & {(A_W+B_W){multiplier[i]}};
    end
  end

  // group g takes copies g, g+4, g+8 ...
  always_comb
  begin
    for (int g = 0; g < 4; g++)
    begin
      group_sum[g] = '0;
      for (int i = g; i < B_W; i += 4)
      begin
        group_sum[g] = group_sum[g] + pp[i];
      end
    end
  end

  // no carry out, full width is enough for A_W x B_W
  assign product = group_sum[0] + group_sum[1] + group_sum[2] + group_sum[3];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the arith_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_arith_core \
  -o tb_arith_core

output=$(./obj_dir/tb_arith_core)
echo "$output"

if echo "$output" | grep -q "^test passed$"; then
  exit 0
else
  exit 1
fi

//--- tb.f
+incdir+include
hdl/fixfloat_pkg.sv
hdl/partial_product_array.sv
hdl/fixed_unit.sv
hdl/float_mul_unit.sv
hdl/arith_core.sv
dv/tb_arith_core.sv
